//--- project.f
i2c_pkg.sv
i2c_quarter_timer.sv
i2c_bit_engine.sv
i2c_byte_engine.sv
i2c_apb_regs.sv
i2c_master.sv
tb_i2c_slave.sv
tb_i2c_master.sv

//--- Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP      ?= tb_i2c_master
FILELIST ?= project.f
BUILD    ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with $(SIM)"
	@echo "  clean  remove build output"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

//--- tb_i2c_master.sv
// Testbench for the I2C master: APB driver, LFSR stimulus, register model, checks, watchdog
`timescale 1ns/10ps
`default_nettype none

module tb_i2c_master;
   import i2c_pkg::*;

   localparam logic [6:0] slave_addr  = 7'h2a;
   localparam int         half_period = 20;
   localparam int         max_cmds    = 300;
   // Slowest byte plus APB overhead in ns
   localparam int longest_cmd_ns = (BYTE_SYMBOLS * (4 * QUARTER_STANDARD + 2) + 40) * 40;

   logic                  sda;
   logic                  reset;
   logic [APB_ADDR_W-1:0] paddr;
   logic                  psel;
   logic                  penable;
   logic                  pwrite;
   logic [APB_DATA_W-1:0] pwdata;
   logic [APB_DATA_W-1:0] prdata;
   logic                  pready;
   logic                  pslverr;
   logic                  bus_clock_low;
   logic                  bus_data_low;
   logic                  pull_up;
   logic                  slave_low;
   wire                   scl_line;
   wire                   data_line;

   logic [31:0] lfsr_q;
   byte_t       model [256];
   int          cycles;

   // Open-drain lines
   // DUT drive only counts with the pull-up enabled
   assign scl_line  = !(pull_up && bus_clock_low);
   assign data_line = !((pull_up && bus_data_low) || slave_low);

   i2c_master u_dut (
      .paddr         (paddr),
      .psel          (psel),
      .penable       (penable),
      .pwrite        (pwrite),
      .pwdata        (pwdata),
      .prdata        (prdata),
      .pready        (pready),
      .pslverr       (pslverr),
      .sda           (sda),
      .reset         (reset),
      .bus_data_in   (data_line),
      .bus_clock_low (bus_clock_low),
      .bus_data_low  (bus_data_low),
      .pull_up       (pull_up)
   );

   tb_i2c_slave u_slave (
      .scl       (scl_line),
      .data_line (data_line),
      .own_addr  (slave_addr),
      .data_low  (slave_low)
   );

   always #half_period sda = !sda;

   always @(negedge sda)
      cycles++;

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
      if (expected !== actual)
         report_failure($sformatf("error: %s expected %0h actual %0h", name, expected, actual));
   endtask

   task automatic check_nack(input string name, input logic expected, input logic actual);
      if (expected !== actual)
         report_failure($sformatf("error: %s expected %0b actual %0b", name, expected, actual));
   endtask

   task automatic check_pslverr(input string name, input logic expected, input logic actual);
      if (expected !== actual)
         report_failure($sformatf("error: %s expected %0b actual %0b", name, expected, actual));
   endtask

   task automatic check_cycles(input string name, input int expected, input int actual);
      if (expected != actual)
         report_failure($sformatf("error: %s expected %0d actual %0d", name, expected, actual));
   endtask

   // Galois LFSR stepped once per bit
   function automatic logic [7:0] random_bits(input int n);
      logic [7:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         r      = {r[6:0], lfsr_q[0]};
         lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
      end
      return r;
   endfunction

   task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data,
                            output logic err);
      @(negedge sda);
      paddr   = addr;
      pwrite  = 1'b1;
      pwdata  = data;
      psel    = 1'b1;
      penable = 1'b0;
      @(negedge sda);
      penable = 1'b1;
      #1 err  = pslverr;
      if (pready !== 1'b1)
         report_failure("pready was low in an APB write access cycle");
      @(negedge sda);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data);
      @(negedge sda);
      paddr   = addr;
      pwrite  = 1'b0;
      psel    = 1'b1;
      penable = 1'b0;
      @(negedge sda);
      penable = 1'b1;
      #1 data = prdata;
      if (pready !== 1'b1)
         report_failure("pready was low in an APB read access cycle");
      @(negedge sda);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic wait_idle(output logic [31:0] status);
      int polls;
      polls = 0;
      apb_read(ADDR_STATUS, status);
      while (status[0])
      begin
         polls++;
         if (polls > 2000)
            report_failure("command did not finish: busy stayed high");
         apb_read(ADDR_STATUS, status);
      end
   endtask

   task automatic run_cmd(input string name, input cmd_op_t op, input byte_t data,
                          output logic [31:0] status);
      logic err;
      apb_write(ADDR_CMD, {16'h0, data, 5'h0, op}, err);
      check_pslverr({name, " pslverr"}, 1'b0, err);
      wait_idle(status);
   endtask

   task automatic write_pair(input byte_t ptr, input byte_t d0, input byte_t d1);
      logic [31:0] st;
      run_cmd("write start", op_start, 8'h00, st);
      run_cmd("write addr", op_write, {slave_addr, 1'b0}, st);
      check_nack("write addr nack", 1'b0, st[1]);
      run_cmd("write ptr", op_write, ptr, st);
      check_nack("write ptr nack", 1'b0, st[1]);
      run_cmd("write data0", op_write, d0, st);
      check_nack("write data0 nack", 1'b0, st[1]);
      run_cmd("write data1", op_write, d1, st);
      check_nack("write data1 nack", 1'b0, st[1]);
      run_cmd("write stop", op_stop, 8'h00, st);
      model[ptr]               = d0;
      model[byte_t'(ptr + 1)]  = d1;
   endtask

   // Start, pointer write, repeated start, read address
   task automatic open_read(input byte_t ptr);
      logic [31:0] st;
      run_cmd("read start", op_start, 8'h00, st);
      run_cmd("read waddr", op_write, {slave_addr, 1'b0}, st);
      check_nack("read waddr nack", 1'b0, st[1]);
      run_cmd("read ptr", op_write, ptr, st);
      check_nack("read ptr nack", 1'b0, st[1]);
      run_cmd("read restart", op_start, 8'h00, st);
      run_cmd("read raddr", op_write, {slave_addr, 1'b1}, st);
      check_nack("read raddr nack", 1'b0, st[1]);
   endtask

   task automatic check_bit_period(input int quarter);
      logic [31:0] st;
      int          first;
      int          second;
      run_cmd("timing start", op_start, 8'h00, st);
      fork
         run_cmd("timing addr", op_write, {slave_addr, 1'b0}, st);
         begin
            @(negedge bus_clock_low);
            first = cycles;
            @(negedge bus_clock_low);
            second = cycles;
         end
      join
      check_cycles("bit period", 4 * quarter + 2, second - first);
      run_cmd("timing stop", op_stop, 8'h00, st);
   endtask

   initial
   begin
      #(max_cmds * longest_cmd_ns * 2);
      $display("watchdog expired before the tests finished");
      $display("Test failed");
      $fatal(1);
   end

   initial
   begin
      logic [31:0] st;
      logic [31:0] rd;
      logic        err;
      byte_t       ptr;
      byte_t       bad;
      int          speed;
      int          quarter;
      int          first_speed;

      sda     = 1'b0;
      reset   = 1'b1;
      paddr   = '0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      pwdata  = '0;
      cycles  = 0;
      lfsr_q  = 32'd74885;
      for (int i = 0; i < 256; i++)
         model[i] = byte_t'(i) ^ 8'h5a;
      repeat (2) @(negedge sda);
      reset = 1'b0;

      // Reset state
      apb_read(ADDR_CTRL, rd);
      check_byte("reset ctrl", 8'h00, rd[7:0]);
      apb_read(ADDR_STATUS, rd);
      check_byte("reset status", 8'h00, rd[7:0]);
      check_byte("reset rx", 8'h00, rd[15:8]);
      check_nack("reset clock drive", 1'b0, bus_clock_low);
      check_nack("reset data drive", 1'b0, bus_data_low);
      check_nack("reset pull-up", 1'b0, pull_up);

      first_speed = random_bits(2) % 3;
      for (int k = 0; k < 3; k++)
      begin
         speed = (first_speed + k) % 3;
         case (speed)
            1:       quarter = QUARTER_FAST;
            2:       quarter = QUARTER_FAST_PLUS;
            default: quarter = QUARTER_STANDARD;
         endcase
         apb_write(ADDR_CTRL, 32'h4 | speed, err);
         check_pslverr("ctrl write", 1'b0, err);
         check_nack("pull-up enable", 1'b1, pull_up);
         check_bit_period(quarter);
         for (int n = 0; n < 3; n++)
         begin
            ptr = random_bits(8);
            write_pair(ptr, random_bits(8), random_bits(8));
            open_read(ptr);
            run_cmd("readback", op_read_nack, 8'h00, st);
            check_byte("readback data", model[ptr], st[15:8]);
            run_cmd("readback stop", op_stop, 8'h00, st);
         end
      end

      // Wrong slave address
      bad = {slave_addr ^ (7'(random_bits(7)) | 7'h01), 1'b0};
      run_cmd("bad start", op_start, 8'h00, st);
      run_cmd("bad addr", op_write, bad, st);
      check_nack("bad addr nack", 1'b1, st[1]);
      run_cmd("bad stop", op_stop, 8'h00, st);

      // Command while busy is refused
      apb_write(ADDR_CMD, {16'h0, 8'h00, 5'h0, op_start}, err);
      check_pslverr("busy first", 1'b0, err);
      apb_write(ADDR_CMD, {16'h0, 8'hff, 5'h0, op_write}, err);
      check_pslverr("busy refused", 1'b1, err);
      wait_idle(st);
      run_cmd("after refusal", op_write, {slave_addr, 1'b0}, st);
      check_nack("after refusal nack", 1'b0, st[1]);
      run_cmd("after refusal stop", op_stop, 8'h00, st);

      // Reserved opcodes
      apb_write(ADDR_CMD, 32'h0000_ab00, err);
      check_pslverr("reserved 0", 1'b1, err);
      apb_write(ADDR_CMD, 32'h0000_ab06, err);
      check_pslverr("reserved 6", 1'b1, err);
      apb_read(ADDR_STATUS, st);
      check_nack("reserved busy", 1'b0, st[0]);

      // Multi-byte read
      ptr = random_bits(8);
      open_read(ptr);
      for (int i = 0; i < 3; i++)
      begin
         run_cmd("multi ack", op_read_ack, 8'h00, st);
         check_byte("multi data", model[byte_t'(ptr + i)], st[15:8]);
      end
      run_cmd("multi nack", op_read_nack, 8'h00, st);
      check_byte("multi last", model[byte_t'(ptr + 3)], st[15:8]);
      check_nack("slave released", 1'b0, slave_low);
      run_cmd("multi stop", op_stop, 8'h00, st);

      $display("Test completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

//--- tb_i2c_slave.sv
// Behavioral I2C slave with a 256-entry register file and an auto-incrementing pointer
`timescale 1ns/10ps
`default_nettype none

module tb_i2c_slave (
   input  wire logic       scl,
   input  wire logic       data_line,
   input  wire logic [6:0] own_addr,
   output logic            data_low
);
   import i2c_pkg::*;

   typedef enum logic [1:0] {mode_idle, mode_addr, mode_write, mode_read} mode_t;

   mode_t mode;
   byte_t regs [256];
   byte_t shift;
   byte_t tx;
   byte_t ptr;
   int    bits;
   logic  read_dir;
   logic  ptr_next;
   logic  master_nack;
   logic  scl_prev;
   logic  data_prev;

   // One process watches both lines, so edge order is never ambiguous
   initial
   begin
      data_low    = 1'b0;
      mode        = mode_idle;
      bits        = 0;
      ptr         = '0;
      shift       = '0;
      tx          = '0;
      read_dir    = 1'b0;
      ptr_next    = 1'b0;
      master_nack = 1'b1;
      scl_prev    = 1'b1;
      data_prev   = 1'b1;
      for (int i = 0; i < 256; i++)
         regs[i] = byte_t'(i) ^ 8'h5a;
      forever
      begin
         @(scl or data_line);
         if (scl_prev && scl && data_prev && !data_line)
         begin
            // START or repeated START
            mode     = mode_addr;
            bits     = 0;
            data_low = 1'b0;
         end
         else if (scl_prev && scl && !data_prev && data_line)
         begin
            mode     = mode_idle;
            data_low = 1'b0;
         end
         else if (!scl_prev && scl && (mode != mode_idle))
         begin
            if (bits < 8)
               shift = {shift[6:0], data_line};
            else
               master_nack = data_line;
            bits++;
         end
         else if (scl_prev && !scl && (mode != mode_idle))
         begin
            if (bits == 8)
            begin
               // ACK slot
               case (mode)
                  mode_addr:
                  begin
                     if (shift[7:1] == own_addr)
                     begin
                        data_low = 1'b1;
                        read_dir = shift[0];
                     end
                     else
                        mode = mode_idle;
                  end
                  mode_write:
                  begin
                     data_low = 1'b1;
                     if (ptr_next)
                        ptr = shift;
                     else
                     begin
                        regs[ptr] = shift;
                        ptr++;
                     end
                     ptr_next = 1'b0;
                  end
                  default: data_low = 1'b0;
               endcase
            end
            else if (bits == 9)
            begin
               bits     = 0;
               data_low = 1'b0;
               if (mode == mode_addr)
               begin
                  mode        = read_dir ? mode_read : mode_write;
                  ptr_next    = !read_dir;
                  master_nack = 1'b0;
               end
               if (mode == mode_read)
               begin
                  if (master_nack)
                     mode = mode_idle;
                  else
                  begin
                     tx       = regs[ptr];
                     ptr++;
                     data_low = !tx[7];
                  end
               end
            end
            else if (mode == mode_read)
               data_low = !tx[7 - bits];
         end
         scl_prev  = scl;
         data_prev = data_line;
      end
   end

endmodule

`default_nettype wire

//--- i2c_master.sv
// I2C master top: APB registers, byte engine, bit engine and quarter timer
`timescale 1ns/10ps
`default_nettype none

module i2c_master (
   input  wire logic [i2c_pkg::APB_ADDR_W-1:0] paddr,
   input  wire logic                           psel,
   input  wire logic                           penable,
   input  wire logic                           pwrite,
   input  wire logic [i2c_pkg::APB_DATA_W-1:0] pwdata,
   output logic [i2c_pkg::APB_DATA_W-1:0]      prdata,
   output logic                                pready,
   output logic                                pslverr,
   input  wire logic                           sda,
   input  wire logic                           reset,
   input  wire logic                           bus_data_in,
   output logic                                bus_clock_low,
   output logic                                bus_data_low,
   output logic                                pull_up
);
   import i2c_pkg::*;

   speed_t  speed;
   logic    cmd_valid;
   cmd_op_t cmd_op;
   byte_t   cmd_data;
   logic    busy;
   logic    nack;
   byte_t   rx_data;
   logic    sym_valid;
   sym_t    sym;
   logic    sym_bit;
   logic    sym_busy;
   logic    sample;
   logic    run;
   logic    tick;

   i2c_apb_regs u_regs (
      .sda       (sda),
      .reset     (reset),
      .paddr     (paddr),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .pwdata    (pwdata),
      .busy      (busy),
      .nack      (nack),
      .rx_data   (rx_data),
      .prdata    (prdata),
      .pready    (pready),
      .pslverr   (pslverr),
      .speed     (speed),
      .pull_up   (pull_up),
      .cmd_valid (cmd_valid),
      .cmd_op    (cmd_op),
      .cmd_data  (cmd_data)
   );

   i2c_byte_engine u_byte (
      .sda       (sda),
      .reset     (reset),
      .cmd_valid (cmd_valid),
      .cmd_op    (cmd_op),
      .cmd_data  (cmd_data),
      .sym_busy  (sym_busy),
      .sample    (sample),
      .busy      (busy),
      .nack      (nack),
      .rx_data   (rx_data),
      .sym_valid (sym_valid),
      .sym       (sym),
      .sym_bit   (sym_bit)
   );

   i2c_bit_engine u_bit (
      .sda           (sda),
      .reset         (reset),
      .sym_valid     (sym_valid),
      .sym           (sym),
      .sym_bit       (sym_bit),
      .tick          (tick),
      .bus_data_in   (bus_data_in),
      .sym_busy      (sym_busy),
      .sample        (sample),
      .run           (run),
      .bus_clock_low (bus_clock_low),
      .bus_data_low  (bus_data_low)
   );

   i2c_quarter_timer u_timer (
      .sda   (sda),
      .reset (reset),
      .speed (speed),
      .run   (run),
      .tick  (tick)
   );

endmodule

`default_nettype wire

//--- i2c_apb_regs.sv
// APB register block: CTRL, CMD and STATUS for the I2C master
`timescale 1ns/10ps
`default_nettype none

module i2c_apb_regs (
   input  wire logic                              sda,
   input  wire logic                              reset,
   input  wire logic [i2c_pkg::APB_ADDR_W-1:0]    paddr,
   input  wire logic                              psel,
   input  wire logic                              penable,
   input  wire logic                              pwrite,
   input  wire logic [i2c_pkg::APB_DATA_W-1:0]    pwdata,
   input  wire logic                              busy,
   input  wire logic                              nack,
   input  wire i2c_pkg::byte_t                    rx_data,
   output logic [i2c_pkg::APB_DATA_W-1:0]         prdata,
   output logic                                   pready,
   output logic                                   pslverr,
   output i2c_pkg::speed_t                        speed,
   output logic                                   pull_up,
   output logic                                   cmd_valid,
   output i2c_pkg::cmd_op_t                       cmd_op,
   output i2c_pkg::byte_t                         cmd_data
);
   import i2c_pkg::*;

   logic access;
   logic cmd_write;
   logic op_ok;

   // Zero wait states
   assign pready    = 1'b1;
   assign access    = psel && penable;
   assign cmd_write = access && pwrite && (paddr == ADDR_CMD);
   assign cmd_op    = cmd_op_t'(pwdata[2:0]);
   assign cmd_data  = pwdata[15:8];

   always_comb
   begin
      case (cmd_op)
         op_start, op_stop, op_write, op_read_ack, op_read_nack: op_ok = 1'b1;
         default: op_ok = 1'b0;
      endcase
   end

   // Refused when busy or reserved opcode
   assign cmd_valid = cmd_write && op_ok && !busy;
   assign pslverr   = cmd_write && !(op_ok && !busy);

   always_ff @(posedge sda)
   begin
      if (reset)
      begin
         speed   <= speed_standard;
         pull_up <= 1'b0;
      end
      else if (access && pwrite && (paddr == ADDR_CTRL))
      begin
         speed   <= speed_t'(pwdata[1:0]);
         pull_up <= pwdata[2];
      end
   end

   // Read mux
   always_comb
   begin
      prdata = '0;
      case (paddr)
         ADDR_CTRL:
         begin
            prdata[1:0] = speed;
            prdata[2]   = pull_up;
         end
         ADDR_STATUS:
         begin
            prdata[0]    = busy;
            prdata[1]    = nack;
            prdata[15:8] = rx_data;
         end
         default: prdata = '0;
      endcase
   end

   // An accepted command always makes the byte engine busy next cycle
   assert property (@(posedge sda) disable iff (reset) cmd_valid |-> !busy ##1 busy);

endmodule

`default_nettype wire

//--- i2c_byte_engine.sv
// I2C byte engine: expands commands into bus symbols, shifts data, records ACK
`timescale 1ns/10ps
`default_nettype none

module i2c_byte_engine (
   input  wire logic             sda,
   input  wire logic             reset,
   input  wire logic             cmd_valid,
   input  wire i2c_pkg::cmd_op_t cmd_op,
   input  wire i2c_pkg::byte_t   cmd_data,
   input  wire logic             sym_busy,
   input  wire logic             sample,
   output logic                  busy,
   output logic                  nack,
   output i2c_pkg::byte_t        rx_data,
   output logic                  sym_valid,
   output i2c_pkg::sym_t         sym,
   output logic                  sym_bit
);
   import i2c_pkg::*;

   typedef enum logic {st_idle, st_run} state_t;

   state_t                 state_q;
   cmd_op_t                op_q;
   byte_t                  tx_q;
   logic [SYM_COUNT_W-1:0] count_q;
   logic [SYM_COUNT_W-1:0] total;
   logic                   is_read;
   logic                   handoff;

   assign busy    = (state_q == st_run);
   assign is_read = (op_q == op_read_ack) || (op_q == op_read_nack);
   assign total   = ((op_q == op_start) || (op_q == op_stop)) ?
                    SYM_COUNT_W'(1) : SYM_COUNT_W'(BYTE_SYMBOLS);
   // Previous symbol just ended, next one may go out in this same cycle
   assign handoff   = busy && !sym_busy;
   assign sym_valid = handoff && (count_q != total);

   always_comb
   begin
      sym_bit = tx_q[DATA_W-1];
      case (op_q)
         op_start: sym = sym_start;
         op_stop:  sym = sym_stop;
         op_write: sym = (count_q < DATA_W) ? sym_send : sym_sample;
         default:
         begin
            sym     = (count_q < DATA_W) ? sym_sample : sym_send;
            sym_bit = (op_q == op_read_nack);
         end
      endcase
   end

   always_ff @(posedge sda)
   begin
      if (reset)
      begin
         state_q <= st_idle;
         op_q    <= op_start;
         count_q <= '0;
         nack    <= 1'b0;
         rx_data <= '0;
      end
      else if (!busy)
      begin
         if (cmd_valid)
         begin
            state_q <= st_run;
            op_q    <= cmd_op;
            count_q <= '0;
            if (cmd_op == op_write)
               nack <= 1'b0;
         end
      end
      else if (handoff)
      begin
         if (count_q == total)
            state_q <= st_idle;
         else
            count_q <= count_q + 1'b1;

         if ((op_q == op_write) && (count_q == SYM_COUNT_W'(BYTE_SYMBOLS)))
            nack <= sample;
         if (is_read && (count_q != '0) && (count_q <= DATA_W))
            rx_data <= {rx_data[DATA_W-2:0], sample};
      end
   end

   // Transmit shifter, MSB first
   always_ff @(posedge sda)
   begin
      if (cmd_valid && !busy)
         tx_q <= cmd_data;
      else if (sym_valid && (sym == sym_send))
         tx_q <= {tx_q[DATA_W-2:0], 1'b0};
   end

   assert property (@(posedge sda) disable iff (reset)
      count_q <= SYM_COUNT_W'(BYTE_SYMBOLS));

endmodule

`default_nettype wire

//--- i2c_bit_engine.sv
// I2C bit engine: one bus symbol (start, stop, send, sample) over four quarter phases
`timescale 1ns/10ps
`default_nettype none

module i2c_bit_engine (
   input  wire logic          sda,
   input  wire logic          reset,
   input  wire logic          sym_valid,
   input  wire i2c_pkg::sym_t sym,
   input  wire logic          sym_bit,
   input  wire logic          tick,
   input  wire logic          bus_data_in,
   output logic               sym_busy,
   output logic               sample,
   output logic               run,
   output logic               bus_clock_low,
   output logic               bus_data_low
);
   import i2c_pkg::*;

   logic       active_q;
   logic [1:0] phase_q;
   logic [1:0] phase_d;
   sym_t       sym_q;
   sym_t       sym_d;
   logic       bit_q;
   logic       bit_d;
   logic       clock_low_d;
   logic       data_low_d;
   logic       accept;
   logic       advance;
   logic       finish;

   assign sym_busy = active_q;
   assign run      = active_q;
   assign accept   = sym_valid && !active_q;
   assign advance  = active_q && tick && (phase_q != 2'd3);
   assign finish   = active_q && tick && (phase_q == 2'd3);

   // Line drives for the phase being entered
   always_comb
   begin
      if (accept)
      begin
         phase_d = 2'd0;
         sym_d   = sym;
         bit_d   = sym_bit;
      end
      else
      begin
         phase_d = phase_q + 2'd1;
         sym_d   = sym_q;
         bit_d   = bit_q;
      end

      // Clock low in the first quarter, and in the last one unless stopping
      clock_low_d = (phase_d == 2'd0) || ((phase_d == 2'd3) && (sym_d != sym_stop));

      case (sym_d)
         sym_start: data_low_d = phase_d[1];   // falls mid-high
         sym_stop:  data_low_d = !phase_d[1];  // rises mid-high
         sym_send:  data_low_d = !bit_d;
         default:   data_low_d = 1'b0;         // released for the slave
      endcase
   end

   always_ff @(posedge sda)
   begin
      if (reset)
      begin
         active_q      <= 1'b0;
         phase_q       <= 2'd0;
         sym_q         <= sym_send;
         bit_q         <= 1'b1;
         bus_clock_low <= 1'b0;
         bus_data_low  <= 1'b0;
         sample        <= 1'b0;
      end
      else
      begin
         if (accept || advance)
         begin
            phase_q       <= phase_d;
            sym_q         <= sym_d;
            bit_q         <= bit_d;
            bus_clock_low <= clock_low_d;
            bus_data_low  <= data_low_d;
         end

         if (accept)
            active_q <= 1'b1;
         else if (finish)
            active_q <= 1'b0;

         // Third quarter, clock still high
         if (active_q && tick && (phase_q == 2'd2) && (sym_q == sym_sample))
            sample <= bus_data_in;
      end
   end

   // Data only moves under a low clock, start and stop excepted
   assert property (@(posedge sda) disable iff (reset)
      $changed(bus_data_low) && (sym_q inside {sym_send, sym_sample}) |-> bus_clock_low);

endmodule

`default_nettype wire

//--- i2c_quarter_timer.sv
// Quarter-bit tick generator for the I2C bit engine
`timescale 1ns/10ps
`default_nettype none

module i2c_quarter_timer (
   input  wire logic            sda,
   input  wire logic            reset,
   input  wire i2c_pkg::speed_t speed,
   input  wire logic            run,
   output logic                 tick
);
   import i2c_pkg::*;

   logic [QUARTER_W-1:0] count_q;
   logic [QUARTER_W-1:0] reload;

   assign reload = quarter_count(speed) - 1'b1;

   always_ff @(posedge sda)
   begin
      if (reset)
      begin
         count_q <= quarter_count(speed_standard) - 1'b1;
         tick    <= 1'b0;
      end
      else
      begin
         tick <= 1'b0;
         if (!run)
            // Parked at a full quarter so the first tick lands one quarter after run
            count_q <= reload;
         else if (count_q == '0)
         begin
            count_q <= reload;
            tick    <= 1'b1;
         end
         else
            count_q <= count_q - 1'b1;
      end
   end

   // A tick only ever appears inside a symbol
   assert property (@(posedge sda) disable iff (reset) $rose(tick) |-> run);

endmodule

`default_nettype wire

//--- i2c_pkg.sv
// Shared definitions for the I2C master: register map, widths, speed table and enums
`default_nettype none

package i2c_pkg;

   // APB register map
   localparam int APB_ADDR_W = 4;
   localparam int APB_DATA_W = 32;
   localparam logic [APB_ADDR_W-1:0] ADDR_CTRL   = 4'h0;
   localparam logic [APB_ADDR_W-1:0] ADDR_CMD    = 4'h4;
   localparam logic [APB_ADDR_W-1:0] ADDR_STATUS = 4'h8;

   // Byte framing on the bus
   localparam int DATA_W       = 8;
   localparam int BYTE_SYMBOLS = 9;
   localparam int SYM_COUNT_W  = $clog2(BYTE_SYMBOLS + 1);

   // System clocks per quarter of a bus bit
   localparam int QUARTER_STANDARD  = 25;
   localparam int QUARTER_FAST      = 6;
   localparam int QUARTER_FAST_PLUS = 3;
   localparam int QUARTER_W         = $clog2(QUARTER_STANDARD + 1);

   typedef enum logic [1:0] {
      speed_standard,
      speed_fast,
      speed_fast_plus
   } speed_t;

   // Codes 0, 6 and 7 are reserved
   typedef enum logic [2:0] {
      op_start     = 3'd1,
      op_stop      = 3'd2,
      op_write     = 3'd3,
      op_read_ack  = 3'd4,
      op_read_nack = 3'd5
   } cmd_op_t;

   typedef enum logic [1:0] {
      sym_start,
      sym_stop,
      sym_send,
      sym_sample
   } sym_t;

   typedef logic [DATA_W-1:0] byte_t;

   // Quarter length for a speed, unknown codes fall back to standard
   function automatic logic [QUARTER_W-1:0] quarter_count(input speed_t speed);
      case (speed)
         speed_fast:      return QUARTER_W'(QUARTER_FAST);
         speed_fast_plus: return QUARTER_W'(QUARTER_FAST_PLUS);
         default:         return QUARTER_W'(QUARTER_STANDARD);
      endcase
   endfunction

endpackage

`default_nettype wire
